// File: verilog/isa_pkg.sv
`default_nettype none

//////////////////////
// Pipeline ISA constants
//////////////////////

package isa_pkg;

    // Instruction and pc width
    // Memory is word addressed, so one pc step is one word
    localparam int WORD_BITS = 32;

    // First address fetched after reset
    // Also the restart point once a program load ends
    localparam logic [WORD_BITS-1:0] RESET_PC = '0;

    // Word presented on the instruction output when nothing is valid
    // All zeros decodes as a nop further down the pipe
    localparam logic [WORD_BITS-1:0] BUBBLE_WORD = '0;

    // Increment between consecutive fetches
    localparam logic [WORD_BITS-1:0] PC_STEP = {{(WORD_BITS-1){1'b0}}, 1'b1};

endpackage

`default_nettype wire

// File: verilog/imem_pkg.sv
`default_nettype none

//////////////////////
// Shared imem port
//////////////////////

package imem_pkg;

    // Bit positions in the request and grant vectors
    // Lower index wins in the fixed-priority arbiter
    localparam int REQ_LOADER = 0;
    localparam int REQ_FETCH = 1;

    // Requesters on the single memory port
    // Also the width of req and gnt
    localparam int NUM_REQ = 2;

endpackage

`default_nettype wire

// File: verilog/instruction_memory.sv
`timescale 1ns/1ns
`default_nettype none

module instruction_memory
#(
    parameter int imem_depth = 256
)
(
    input  wire logic                           clk,
    input  wire logic                           we,
    input  wire logic [$clog2(imem_depth)-1:0]  addr,
    input  wire logic [isa_pkg::WORD_BITS-1:0]  wdata,
    output logic      [isa_pkg::WORD_BITS-1:0]  rdata
);

    import isa_pkg::*;

    // Word storage, undefined until the loader fills it
    logic [WORD_BITS-1:0] mem [imem_depth];

    //////////////////////
    // Single port access
    //////////////////////

    always_ff @(posedge clk)
    begin
        // Write lands in the cycle the port is granted to the loader
        if (we)
        begin
            mem[addr] <= wdata;
        end
        // Registered read, data one cycle after the address
        rdata <= mem[addr];
    end

    //////////////////////
    // Checks
    //////////////////////

    // Address must be resolved whenever a write uses the port
    a_addr_known : assert property (@(posedge clk) we |-> !$isunknown(addr))
        else $error("imem write with unknown address");

endmodule

`default_nettype wire

// File: verilog/imem_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module imem_arbiter
#(
    parameter int imem_depth = 256
)
(
    input  wire logic                           clk,
    input  wire logic                           rst,
    input  wire logic [imem_pkg::NUM_REQ-1:0]   req,
    input  wire logic [$clog2(imem_depth)-1:0]  load_addr,
    input  wire logic [isa_pkg::WORD_BITS-1:0]  load_data,
    input  wire logic [$clog2(imem_depth)-1:0]  fetch_addr,
    output logic      [imem_pkg::NUM_REQ-1:0]   gnt,
    output logic                                mem_we,
    output logic      [$clog2(imem_depth)-1:0]  mem_addr,
    output logic      [isa_pkg::WORD_BITS-1:0]  mem_wdata
);

    import imem_pkg::*;

    // Width of the starvation counter
    localparam int deny_bits = 8;

    // Consecutive cycles in which fetch asked and lost
    logic [deny_bits-1:0] deny_cnt;

    //////////////////////
    // Grant
    //////////////////////

    // Loader always wins and fetch takes what is left
    always_comb
    begin
        gnt             = '0;
        gnt[REQ_LOADER] = req[REQ_LOADER];
        gnt[REQ_FETCH]  = req[REQ_FETCH] & ~req[REQ_LOADER];
    end

    // Steer the port from whoever holds the grant
    // Only the loader ever writes
    always_comb
    begin
        mem_we = gnt[REQ_LOADER];
        if (gnt[REQ_LOADER])
        begin
            mem_addr  = load_addr;
            mem_wdata = load_data;
        end
        else
        begin
            mem_addr  = fetch_addr;
            mem_wdata = '0;
        end
    end

    //////////////////////
    // Denial tracking
    //////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            deny_cnt <= '0;
        end
        else if (req[REQ_FETCH] && !gnt[REQ_FETCH])
        begin
            // Saturate rather than wrap
            if (deny_cnt != '1)
            begin
                deny_cnt <= deny_cnt + 1'b1;
            end
        end
        else
        begin
            deny_cnt <= '0;
        end
    end

    //////////////////////
    // Checks
    //////////////////////

    // No backlog of denied fetches once the loader is idle
    a_no_starve : assert property (@(posedge clk) disable iff (rst)
        !req[REQ_LOADER] |-> (deny_cnt == '0))
        else $error("fetch denied while loader idle");

    // Never two owners of the port
    a_gnt_onehot : assert property (@(posedge clk) disable iff (rst) $onehot0(gnt))
        else $error("imem grant not one-hot");

endmodule

`default_nettype wire

// File: verilog/program_loader.sv
`timescale 1ns/1ns
`default_nettype none

module program_loader
#(
    parameter int imem_depth = 256
)
(
    input  wire logic                           clk,
    input  wire logic                           rst,
    input  wire logic                           load_en,
    input  wire logic                           load_we,
    input  wire logic [$clog2(imem_depth)-1:0]  load_word_addr,
    input  wire logic [isa_pkg::WORD_BITS-1:0]  load_word,
    output logic                                load_req,
    output logic      [$clog2(imem_depth)-1:0]  load_addr,
    output logic      [isa_pkg::WORD_BITS-1:0]  load_data,
    output logic                                halt,
    output logic                                restart,
    output logic      [isa_pkg::WORD_BITS-1:0]  load_count,
    output logic      [isa_pkg::WORD_BITS-1:0]  load_checksum
);

    import isa_pkg::*;

    // load_en one cycle late, for edge detection
    logic load_en_q;
    // First cycle of a load
    logic load_start;

    assign load_start = load_en & ~load_en_q;

    //////////////////////
    // Fetch control
    //////////////////////

    // Halt also covers the cycle after load_en falls,
    // when the last registered write is still going out
    assign halt    = load_en | load_en_q;
    // One cycle at the falling edge of load_en
    assign restart = load_en_q & ~load_en;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            load_en_q <= 1'b0;
            load_req  <= 1'b0;
        end
        else
        begin
            load_en_q <= load_en;
            load_req  <= load_we & load_en;
        end
    end

    // Write payload, follows load_req by construction
    always_ff @(posedge clk)
    begin
        if (load_we)
        begin
            load_addr <= load_word_addr;
            load_data <= load_word;
        end
    end

    //////////////////////
    // Count and checksum
    //////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            load_count    <= '0;
            load_checksum <= '0;
        end
        else if (load_start)
        begin
            // A write in the very first cycle still counts
            load_count    <= load_we ? PC_STEP : '0;
            load_checksum <= load_we ? load_word : '0;
        end
        else if (load_we && load_en)
        begin
            load_count    <= load_count + 1'b1;
            load_checksum <= load_checksum ^ load_word;
        end
    end

    // Writes only inside a load window
    a_we_in_load : assert property (@(posedge clk) disable iff (rst) load_we |-> load_en)
        else $error("load_we outside load_en");

endmodule

`default_nettype wire

// File: verilog/instruction_fetch.sv
`timescale 1ns/1ns
`default_nettype none

module instruction_fetch
#(
    parameter int imem_depth = 256
)
(
    input  wire logic                           clk,
    input  wire logic                           rst,
    input  wire logic                           stall,
    input  wire logic                           redirect,
    input  wire logic [isa_pkg::WORD_BITS-1:0]  redirect_pc,
    input  wire logic                           halt,
    input  wire logic                           restart,
    input  wire logic [isa_pkg::WORD_BITS-1:0]  mem_rdata,
    input  wire logic                           fetch_gnt,
    output logic                                fetch_req,
    output logic      [$clog2(imem_depth)-1:0]  fetch_addr,
    output logic      [isa_pkg::WORD_BITS-1:0]  instr,
    output logic      [isa_pkg::WORD_BITS-1:0]  instr_pc,
    output logic      [isa_pkg::WORD_BITS-1:0]  instr_pc_next,
    output logic                                instr_valid
);

    import isa_pkg::*;

    localparam int addr_bits = $clog2(imem_depth);

    // Address of the next read to issue
    logic [WORD_BITS-1:0] pc;
    // Tag of the read in flight, becomes the output tag
    logic                 flight_live;
    logic [WORD_BITS-1:0] flight_pc;
    logic [WORD_BITS-1:0] flight_pc_next;
    // Read issued and accepted this cycle
    logic                 read_ok;

    //////////////////////
    // Read issue
    //////////////////////

    // No requests while the loader owns the memory
    assign fetch_req = ~halt;
    assign read_ok   = fetch_req & fetch_gnt;

    // On stall, re-read the word being shown
    // so it is still on mem_rdata next cycle
    always_comb
    begin
        if (stall)
        begin
            fetch_addr = flight_pc[addr_bits-1:0];
        end
        else
        begin
            fetch_addr = pc[addr_bits-1:0];
        end
    end

    //////////////////////
    // Pc and in-flight tag
    //////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pc          <= RESET_PC;
            flight_live <= 1'b0;
        end
        else if (restart)
        begin
            // Load just ended, start over from the top
            pc          <= RESET_PC;
            flight_live <= 1'b0;
        end
        else if (redirect)
        begin
            // Wrong-path read dropped, even under stall
            pc          <= redirect_pc;
            flight_live <= 1'b0;
        end
        else if (halt)
        begin
            flight_live <= 1'b0;
        end
        else if (stall)
        begin
            // Hold, valid survives only if the re-read went out
            flight_live <= flight_live & fetch_gnt;
        end
        else
        begin
            flight_live <= read_ok;
            if (read_ok)
            begin
                pc <= pc + PC_STEP;
            end
        end
    end

    // Pc tags of the accepted read
    always_ff @(posedge clk)
    begin
        if (!stall && read_ok)
        begin
            flight_pc      <= pc;
            flight_pc_next <= pc + PC_STEP;
        end
    end

    //////////////////////
    // Output
    //////////////////////

    // Data comes straight off the registered memory read
    assign instr         = flight_live ? mem_rdata : BUBBLE_WORD;
    assign instr_pc      = flight_pc;
    assign instr_pc_next = flight_pc_next;
    assign instr_valid   = flight_live;

    // Redirect from the pipe and restart from the loader must not collide
    a_no_redirect_restart : assert property (@(posedge clk) disable iff (rst)
        !(redirect && restart))
        else $error("redirect and restart in the same cycle");

endmodule

`default_nettype wire

// File: verilog/fetch_subsystem.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_subsystem
#(
    parameter int imem_depth = 256
)
(
    input  wire logic                           clk,
    input  wire logic                           rst,
    input  wire logic                           stall,
    input  wire logic                           redirect,
    input  wire logic [isa_pkg::WORD_BITS-1:0]  redirect_pc,
    input  wire logic                           load_en,
    input  wire logic                           load_we,
    input  wire logic [$clog2(imem_depth)-1:0]  load_word_addr,
    input  wire logic [isa_pkg::WORD_BITS-1:0]  load_word,
    output logic      [isa_pkg::WORD_BITS-1:0]  instr,
    output logic      [isa_pkg::WORD_BITS-1:0]  instr_pc,
    output logic      [isa_pkg::WORD_BITS-1:0]  instr_pc_next,
    output logic                                instr_valid,
    output logic      [isa_pkg::WORD_BITS-1:0]  load_count,
    output logic      [isa_pkg::WORD_BITS-1:0]  load_checksum
);

    import isa_pkg::*;
    import imem_pkg::*;

    localparam int addr_bits = $clog2(imem_depth);

    // Loader side
    logic                 load_req;
    logic [addr_bits-1:0] load_addr;
    logic [WORD_BITS-1:0] load_data;
    logic                 halt;
    logic                 restart;
    // Fetch side
    logic                 fetch_req;
    logic                 fetch_gnt;
    logic [addr_bits-1:0] fetch_addr;
    // Arbiter
    logic [NUM_REQ-1:0]   req;
    logic [NUM_REQ-1:0]   gnt;
    // Memory port
    logic                 mem_we;
    logic [addr_bits-1:0] mem_addr;
    logic [WORD_BITS-1:0] mem_wdata;
    logic [WORD_BITS-1:0] mem_rdata;

    assign req[REQ_LOADER] = load_req;
    assign req[REQ_FETCH]  = fetch_req;
    assign fetch_gnt       = gnt[REQ_FETCH];

    program_loader #(.imem_depth(imem_depth)) i_loader
    (
        .clk            (clk),
        .rst            (rst),
        .load_en        (load_en),
        .load_we        (load_we),
        .load_word_addr (load_word_addr),
        .load_word      (load_word),
        .load_req       (load_req),
        .load_addr      (load_addr),
        .load_data      (load_data),
        .halt           (halt),
        .restart        (restart),
        .load_count     (load_count),
        .load_checksum  (load_checksum)
    );

    instruction_fetch #(.imem_depth(imem_depth)) i_fetch
    (
        .clk            (clk),
        .rst            (rst),
        .stall          (stall),
        .redirect       (redirect),
        .redirect_pc    (redirect_pc),
        .halt           (halt),
        .restart        (restart),
        .mem_rdata      (mem_rdata),
        .fetch_gnt      (fetch_gnt),
        .fetch_req      (fetch_req),
        .fetch_addr     (fetch_addr),
        .instr          (instr),
        .instr_pc       (instr_pc),
        .instr_pc_next  (instr_pc_next),
        .instr_valid    (instr_valid)
    );

    imem_arbiter #(.imem_depth(imem_depth)) i_arbiter
    (
        .clk            (clk),
        .rst            (rst),
        .req            (req),
        .load_addr      (load_addr),
        .load_data      (load_data),
        .fetch_addr     (fetch_addr),
        .gnt            (gnt),
        .mem_we         (mem_we),
        .mem_addr       (mem_addr),
        .mem_wdata      (mem_wdata)
    );

    instruction_memory #(.imem_depth(imem_depth)) i_imem
    (
        .clk            (clk),
        .we             (mem_we),
        .addr           (mem_addr),
        .wdata          (mem_wdata),
        .rdata          (mem_rdata)
    );

endmodule

`default_nettype wire

// File: bench/tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock
#(
    parameter int period       = 20,
    parameter int reset_cycles = 16
)
(
    output logic clk,
    output logic rst
);

    // Free-running clock
    initial
    begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // Reset from time zero, released just after a rising edge
    initial
    begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #2 rst = 1'b0;
    end

endmodule

`default_nettype wire

// File: bench/fetch_subsystem_tb.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_subsystem_tb;

    import isa_pkg::*;

    localparam int depth      = 256;
    localparam int addr_bits  = $clog2(depth);
    localparam int wait_limit = 20;
    // Galois taps for the right-shifting form
    localparam logic [31:0] lfsr_taps = 32'hA300_0000;
    localparam logic [31:0] lfsr_seed = 32'd99;

    logic                 clk;
    logic                 rst;
    logic                 stall;
    logic                 redirect;
    logic [WORD_BITS-1:0] redirect_pc;
    logic                 load_en;
    logic                 load_we;
    logic [addr_bits-1:0] load_word_addr;
    logic [WORD_BITS-1:0] load_word;
    logic [WORD_BITS-1:0] instr;
    logic [WORD_BITS-1:0] instr_pc;
    logic [WORD_BITS-1:0] instr_pc_next;
    logic                 instr_valid;
    logic [WORD_BITS-1:0] load_count;
    logic [WORD_BITS-1:0] load_checksum;

    // Reference image of every word written so far
    logic [WORD_BITS-1:0] ref_mem [depth];
    bit                   ref_known [depth];
    logic [31:0]          lfsr_state;
    int                   errors;
    int                   checks;

    tb_clock #(.period(20), .reset_cycles(16)) i_clock
    (
        .clk (clk),
        .rst (rst)
    );

    fetch_subsystem #(.imem_depth(depth)) i_dut
    (
        .clk            (clk),
        .rst            (rst),
        .stall          (stall),
        .redirect       (redirect),
        .redirect_pc    (redirect_pc),
        .load_en        (load_en),
        .load_we        (load_we),
        .load_word_addr (load_word_addr),
        .load_word      (load_word),
        .instr          (instr),
        .instr_pc       (instr_pc),
        .instr_pc_next  (instr_pc_next),
        .instr_valid    (instr_valid),
        .load_count     (load_count),
        .load_checksum  (load_checksum)
    );

    //////////////////////
    // Helpers
    //////////////////////

    // Observe and drive just after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0])
        begin
            return (s >> 1) ^ lfsr_taps;
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit
    task automatic draw_word(output logic [WORD_BITS-1:0] w);
        w = '0;
        for (int i = 0; i < WORD_BITS; i++)
        begin
            lfsr_state = lfsr_step(lfsr_state);
            w = {w[WORD_BITS-2:0], lfsr_state[0]};
        end
    endtask

    task automatic check_word(input string test, input string what,
                              input logic [WORD_BITS-1:0] expected,
                              input logic [WORD_BITS-1:0] actual);
        checks++;
        assert (actual === expected)
        else
        begin
            errors++;
            $display("Fail %s: %s expected %h, actual %h", test, what, expected, actual);
        end
    endtask

    task automatic check_true(input string test, input bit cond, input string msg);
        checks++;
        assert (cond)
        else
        begin
            errors++;
            $display("%s: %s", test, msg);
        end
    endtask

    // Valid instruction at exp_pc carrying the reference word
    task automatic check_fetch(input string test, input logic [WORD_BITS-1:0] exp_pc);
        check_true(test, instr_valid === 1'b1, "instr_valid low where an instruction was due");
        check_word(test, "instr_pc", exp_pc, instr_pc);
        check_word(test, "instr_pc_next", exp_pc + 32'd1, instr_pc_next);
        if (exp_pc[WORD_BITS-1:addr_bits] == '0 && ref_known[exp_pc[addr_bits-1:0]])
        begin
            check_word(test, "instr", ref_mem[exp_pc[addr_bits-1:0]], instr);
        end
        else
        begin
            check_true(test, 1'b0, "expected pc lies outside the loaded words");
        end
    endtask

    task automatic wait_valid(input string test, output int waited);
        waited = 0;
        while (instr_valid !== 1'b1 && waited < wait_limit)
        begin
            next_cycle();
            waited++;
        end
        check_true(test, instr_valid === 1'b1, "timeout waiting for instr_valid");
    endtask

    // Whole load window with fetch silenced after the first edge
    task automatic write_program(input string test, input int base, input int n_words,
                                 output logic [WORD_BITS-1:0] sum);
        logic [WORD_BITS-1:0] w;
        sum     = '0;
        load_en = 1'b1;
        load_we = 1'b0;
        next_cycle();
        for (int i = 0; i < n_words; i++)
        begin
            check_true(test, instr_valid === 1'b0, "instr_valid high during a load");
            draw_word(w);
            ref_mem[base + i]   = w;
            ref_known[base + i] = 1'b1;
            sum                 = sum ^ w;
            load_we             = 1'b1;
            load_word_addr      = addr_bits'(base + i);
            load_word           = w;
            next_cycle();
        end
        load_we = 1'b0;
        // Last write still draining into memory
        next_cycle();
        check_true(test, instr_valid === 1'b0, "instr_valid high during a load");
    endtask

    // End of load followed by a run from the reset pc
    task automatic restart_and_follow(input string test, input int n_after);
        int waited;
        load_en = 1'b0;
        next_cycle();
        check_true(test, instr_valid === 1'b0, "instr_valid high in the restart cycle");
        wait_valid(test, waited);
        check_fetch(test, 32'd0);
        for (int i = 1; i <= n_after; i++)
        begin
            next_cycle();
            check_fetch(test, WORD_BITS'(i));
        end
    endtask

    task automatic report_test(input string name, input int errs0);
        $display("Test %s finished with %0d errors", name, errors - errs0);
    endtask

    //////////////////////
    // Directed tests
    //////////////////////

    task automatic initial_load();
        int                   errs0;
        logic [WORD_BITS-1:0] sum;
        errs0 = errors;
        write_program("load", 0, 64, sum);
        check_word("load", "load_count", 32'd64, load_count);
        check_word("load", "load_checksum", sum, load_checksum);
        report_test("load", errs0);
    endtask

    task automatic restart_and_sequence();
        int errs0;
        errs0 = errors;
        restart_and_follow("restart", 15);
        report_test("restart", errs0);
    endtask

    task automatic stall_hold();
        int                   errs0;
        logic [WORD_BITS-1:0] exp;
        logic [WORD_BITS-1:0] held_instr;
        logic [WORD_BITS-1:0] held_pc;
        logic [WORD_BITS-1:0] held_pc_next;
        logic                 held_valid;
        errs0 = errors;
        exp   = instr_pc;
        for (int i = 0; i < 3; i++)
        begin
            next_cycle();
            exp = exp + 32'd1;
            check_fetch("stall", exp);
        end
        held_instr   = instr;
        held_pc      = instr_pc;
        held_pc_next = instr_pc_next;
        held_valid   = instr_valid;
        stall        = 1'b1;
        for (int i = 0; i < 5; i++)
        begin
            next_cycle();
            check_word("stall", "held instr", held_instr, instr);
            check_word("stall", "held instr_pc", held_pc, instr_pc);
            check_word("stall", "held instr_pc_next", held_pc_next, instr_pc_next);
            check_true("stall", instr_valid === held_valid, "instr_valid changed under stall");
        end
        stall = 1'b0;
        // Sequence picks up at the next pc with nothing lost or doubled
        for (int i = 0; i < 6; i++)
        begin
            next_cycle();
            exp = exp + 32'd1;
            check_fetch("stall", exp);
        end
        report_test("stall", errs0);
    endtask

    task automatic redirect_jump();
        int                   errs0;
        int                   waited;
        logic [WORD_BITS-1:0] target;
        errs0       = errors;
        target      = 32'd8;
        redirect    = 1'b1;
        redirect_pc = target;
        next_cycle();
        redirect = 1'b0;
        // Read in flight at the redirect belongs to the wrong path
        check_true("redirect", instr_valid === 1'b0, "wrong-path instruction delivered");
        wait_valid("redirect", waited);
        check_fetch("redirect", target);
        for (int i = 1; i <= 5; i++)
        begin
            next_cycle();
            check_fetch("redirect", target + WORD_BITS'(i));
        end
        report_test("redirect", errs0);
    endtask

    task automatic reload_while_running();
        int                   errs0;
        logic [WORD_BITS-1:0] sum;
        errs0 = errors;
        check_true("reload", instr_valid === 1'b1, "fetch not running before the reload");
        write_program("reload", 0, 32, sum);
        check_word("reload", "load_count", 32'd32, load_count);
        check_word("reload", "load_checksum", sum, load_checksum);
        // Crosses from new words into the first program's words
        restart_and_follow("reload", 40);
        report_test("reload", errs0);
    endtask

    //////////////////////
    // Main sequence
    //////////////////////

    initial
    begin
        int n;
        stall          = 1'b0;
        redirect       = 1'b0;
        redirect_pc    = '0;
        load_en        = 1'b0;
        load_we        = 1'b0;
        load_word_addr = '0;
        load_word      = '0;
        lfsr_state     = lfsr_seed;
        errors         = 0;
        checks         = 0;
        for (int i = 0; i < depth; i++)
        begin
            ref_known[i] = 1'b0;
        end
        n = 0;
        do
        begin
            @(negedge clk);
            n++;
        end
        while (rst !== 1'b0 && n < 64);
        check_true("reset", rst === 1'b0, "reset never released");
        next_cycle();

        initial_load();
        restart_and_sequence();
        stall_hold();
        redirect_jump();
        reload_while_running();

        $display("Summary: 5 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0)
        begin
            $display("No errors");
        end
        else
        begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: fetch_subsystem.f
verilog/isa_pkg.sv
verilog/imem_pkg.sv
verilog/instruction_memory.sv
verilog/imem_arbiter.sv
verilog/program_loader.sv
verilog/instruction_fetch.sv
verilog/fetch_subsystem.sv
bench/tb_clock.sv
bench/fetch_subsystem_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the fetch subsystem testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module fetch_subsystem_tb \
    -f fetch_subsystem.f -o fetch_subsystem_sim &&
./obj_dir/fetch_subsystem_sim | tee /dev/stderr | grep -x "No errors" > /dev/null &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
